/* cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_ctrl (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    valid,
  input  cache_pkg::addr_t        addr,
  output logic                    addr_ok,
  output logic                    data_ok,
  output logic                    rd_req,
  output cache_pkg::addr_t        rd_addr,
  input  logic                    rd_rdy,
  input  logic                    ret_valid,
  input  logic                    ret_last,
  input  logic                    hit,
  output cache_pkg::index_t       ram_index,
  output cache_pkg::tag_t         req_tag,
  output cache_pkg::bank_t        req_bank,
  output logic                    lookup_hit,
  output logic                    refill_active,
  output cache_pkg::way_t         victim_way,
  output logic [`CACHE_WAYS-1:0]  tag_we
);

  typedef enum logic [1:0] {
    st_idle,
    st_lookup,
    st_replace,
    st_refill
  } state_t;

  state_t state;
  state_t state_nxt;
  cache_pkg::addr_t req_addr_r;
  logic [`CACHE_LFSR_W-1:0] lfsr;
  logic accept;
  logic last_beat;

  assign accept    = valid && addr_ok;
  assign last_beat = refill_active && ret_valid && ret_last;

  ////////////////////
  // state machine
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:    if (valid) state_nxt = st_lookup;
      st_lookup:  state_nxt = hit ? st_idle : st_replace;
      st_replace: if (rd_rdy) state_nxt = st_refill;
      st_refill:  if (ret_valid && ret_last) state_nxt = st_idle;
      default:    state_nxt = st_idle;
    endcase
  end

  assign addr_ok       = (state == st_idle);
  assign lookup_hit    = (state == st_lookup) && hit;
  assign refill_active = (state == st_refill);
  assign rd_req        = (state == st_replace);   // held until rd_rdy

  // request buffer
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr_r <= addr;
    end
  end

  assign req_tag  = req_addr_r[31 -: `CACHE_TAG_W];
  assign req_bank = req_addr_r[2 +: `CACHE_BANK_W];
  assign rd_addr  = {req_addr_r[31:4], 4'b0000};   // line aligned

  // RAMs read ahead with the incoming address while idle
  assign ram_index = addr_ok ? addr[`CACHE_BANK_W+2 +: `CACHE_INDEX_W]
                             : req_addr_r[`CACHE_BANK_W+2 +: `CACHE_INDEX_W];

  ////////////////////
  // victim choice
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      lfsr       <= `CACHE_LFSR_SEED;
      victim_way <= 1'b0;
    end else begin
      lfsr <= {lfsr[`CACHE_LFSR_W-2:0], lfsr[`CACHE_LFSR_TAP_A] ^ lfsr[`CACHE_LFSR_TAP_B]};
      if ((state == st_lookup) && !hit) begin
        victim_way <= lfsr[0];             // fixed for the whole refill
      end
    end
  end

  // new tag goes in with the last beat
  always_comb begin
    tag_we = '0;
    tag_we[victim_way] = last_beat;
  end

  // response strobe, one cycle after the hit or the last beat
  always_ff @(posedge clk) begin
    if (!resetn) begin
      data_ok <= 1'b0;
    end else begin
      data_ok <= lookup_hit || last_beat;
    end
  end

endmodule

/* cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

`define CACHE_TAG_W       20            // addr[31:12]
`define CACHE_INDEX_W     8             // addr[11:4]
`define CACHE_SETS        256
`define CACHE_BANK_W      2             // addr[3:2]
`define CACHE_BANKS       4
`define CACHE_WAYS        2
`define CACHE_LFSR_W      23
`define CACHE_LFSR_SEED   23'h5500FF
`define CACHE_LFSR_TAP_A  22
`define CACHE_LFSR_TAP_B  17

`endif

/* cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

  typedef logic [31:0] addr_t;                    // byte address
  typedef logic [31:0] word_t;
  typedef logic [`CACHE_TAG_W-1:0] tag_t;
  typedef logic [`CACHE_INDEX_W-1:0] index_t;
  typedef logic [`CACHE_BANK_W-1:0] bank_t;       // word within a line
  typedef logic way_t;

  // one tag RAM entry
  typedef struct packed {
    tag_t tag;
    logic valid;
  } tag_entry_t;

endpackage

/* cache_top.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_top (
  input  logic             clk,
  input  logic             resetn,
  // processor side
  input  logic             valid,
  input  cache_pkg::addr_t addr,
  output logic             addr_ok,
  output logic             data_ok,
  output cache_pkg::word_t rdata,
  // memory side
  output logic             rd_req,
  output cache_pkg::addr_t rd_addr,
  input  logic             rd_rdy,
  input  logic             ret_valid,
  input  logic             ret_last,
  input  cache_pkg::word_t ret_data
);

  cache_pkg::index_t ram_index;
  cache_pkg::tag_t req_tag;
  cache_pkg::bank_t req_bank;
  logic lookup_hit;
  logic refill_active;
  cache_pkg::way_t victim_way;
  logic [`CACHE_WAYS-1:0] tag_we;
  logic [`CACHE_BANKS-1:0] bank_we;
  logic hit;
  cache_pkg::word_t hit_word;
  cache_pkg::tag_entry_t tag_wdata;
  cache_pkg::tag_entry_t tag_rd [`CACHE_WAYS];
  cache_pkg::word_t data_rd [`CACHE_WAYS][`CACHE_BANKS];

  assign tag_wdata = '{tag: req_tag, valid: 1'b1};

  cache_ctrl u_ctrl (
    .clk(clk), .resetn(resetn),
    .valid(valid), .addr(addr), .addr_ok(addr_ok), .data_ok(data_ok),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
    .ret_valid(ret_valid), .ret_last(ret_last), .hit(hit),
    .ram_index(ram_index), .req_tag(req_tag), .req_bank(req_bank),
    .lookup_hit(lookup_hit), .refill_active(refill_active),
    .victim_way(victim_way), .tag_we(tag_we)
  );

  ////////////////////
  // tag and data RAMs
  ////////////////////

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    way_ram #(.entry_t(cache_pkg::tag_entry_t)) u_tag_ram (
      .clk(clk), .we(tag_we[w]), .addr(ram_index),
      .wdata(tag_wdata), .rdata(tag_rd[w])
    );
    for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
      way_ram #(.entry_t(cache_pkg::word_t)) u_data_ram (
        .clk(clk),
        .we(bank_we[b] && (victim_way == cache_pkg::way_t'(w))),  // victim only
        .addr(ram_index),
        .wdata(ret_data),
        .rdata(data_rd[w][b])
      );
    end
  end

  hit_select u_hit (
    .tag_rd0(tag_rd[0]), .tag_rd1(tag_rd[1]), .req_tag(req_tag), .bank(req_bank),
    .data_rd0(data_rd[0]), .data_rd1(data_rd[1]),
    .hit(hit), .hit_way(), .hit_word(hit_word)
  );

  refill_unit u_refill (
    .clk(clk), .resetn(resetn),
    .refill_active(refill_active), .ret_valid(ret_valid), .ret_data(ret_data),
    .bank(req_bank), .lookup_hit(lookup_hit),
    .hit_word(hit_word),
    .bank_we(bank_we), .rdata(rdata)
  );

endmodule

/* hit_select.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module hit_select (
  input  cache_pkg::tag_entry_t tag_rd0,
  input  cache_pkg::tag_entry_t tag_rd1,
  input  cache_pkg::tag_t       req_tag,
  input  cache_pkg::bank_t      bank,
  input  cache_pkg::word_t      data_rd0 [`CACHE_BANKS],
  input  cache_pkg::word_t      data_rd1 [`CACHE_BANKS],
  output logic                  hit,
  output cache_pkg::way_t       hit_way,
  output cache_pkg::word_t      hit_word
);

  logic way0_hit;
  logic way1_hit;
  cache_pkg::word_t way0_word;
  cache_pkg::word_t way1_word;

  ////////////////////
  // tag compare
  ////////////////////

  assign way0_hit = tag_rd0.valid && (tag_rd0.tag == req_tag);
  assign way1_hit = tag_rd1.valid && (tag_rd1.tag == req_tag);

  assign hit     = way0_hit || way1_hit;
  assign hit_way = way1_hit;               // a line never sits in both ways

  ////////////////////
  // word select
  ////////////////////

  assign way0_word = data_rd0[bank];
  assign way1_word = data_rd1[bank];

  assign hit_word = way1_hit ? way1_word : way0_word;

endmodule

/* refill_unit.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module refill_unit (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     refill_active,
  input  logic                     ret_valid,
  input  cache_pkg::word_t         ret_data,
  input  cache_pkg::bank_t         bank,
  input  logic                     lookup_hit,
  input  cache_pkg::word_t         hit_word,
  output logic [`CACHE_BANKS-1:0]  bank_we,
  output cache_pkg::word_t         rdata
);

  cache_pkg::bank_t beat_cnt;
  logic beat;

  assign beat = refill_active && ret_valid;

  // beat counter, idle at zero between refills
  always_ff @(posedge clk) begin
    if (!resetn || !refill_active) begin
      beat_cnt <= '0;
    end else if (ret_valid) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // one bank per beat, ascending order
  always_comb begin
    bank_we = '0;
    if (beat) begin
      bank_we[beat_cnt] = 1'b1;
    end
  end

  ////////////////////
  // response word
  ////////////////////

  always_ff @(posedge clk) begin
    if (lookup_hit) begin
      rdata <= hit_word;
    end else if (beat && (beat_cnt == bank)) begin
      rdata <= ret_data;                   // critical word from the burst
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the cache testbench, then look for the pass line in the log
verilator --binary --timing --assert --timescale 1ns/1ps --x-initial 0 -Wno-fatal \
  -f sim.f --top-module tb_cache -o tb_cache_sim > build.log 2>&1 \
  && ./obj_dir/tb_cache_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* sim.f */
+incdir+.
cache_pkg.sv
way_ram.sv
hit_select.sv
refill_unit.sv
cache_ctrl.sv
cache_top.sv
tb_cache.sv

/* tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

  localparam int TIMEOUT_CYCLES = 16000;            // 200 requests x 40 cycles x 2
  localparam int NUM_REQUESTS   = 200;
  localparam logic [31:0] MEM_KEY = 32'hA5C3_0F96;

  logic clk = 1'b0;
  logic resetn;
  logic valid;
  cache_pkg::addr_t addr;
  logic addr_ok;
  logic data_ok;
  cache_pkg::word_t rdata;
  logic rd_req;
  cache_pkg::addr_t rd_addr;
  logic rd_rdy;
  logic ret_valid;
  logic ret_last;
  cache_pkg::word_t ret_data;

  integer seed = 60;
  int cycle = 0;
  int errors = 0;
  int requests = 0;
  int responses = 0;
  int acc_cycle = 0;
  logic pending = 1'b0;                             // accepted, no data_ok yet
  logic want_hit = 1'b0;
  logic miss_seen = 1'b0;
  logic prev_wait = 1'b0;                           // rd_req without rd_rdy last cycle
  cache_pkg::addr_t cur_addr = '0;
  cache_pkg::addr_t prev_rd_addr = '0;

  cache_top uut (
    .clk(clk), .resetn(resetn),
    .valid(valid), .addr(addr), .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
    .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data)
  );

  always #4 clk = ~clk;

  // memory contents, one word per aligned byte address
  function automatic cache_pkg::word_t mem_word(input cache_pkg::addr_t a);
    return {a[31:2], 2'b00} ^ MEM_KEY;
  endfunction

  function automatic cache_pkg::addr_t line_addr(input logic [19:0] tag,
                                                 input logic [7:0] index,
                                                 input logic [1:0] bank);
    return {tag, index, bank, 2'b00};
  endfunction

  // three tags over two indices, so sets see evictions
  function automatic cache_pkg::addr_t pool_addr();
    int t;
    int s;
    int w;
    logic [19:0] tag;
    t = $unsigned($random(seed)) % 3;
    s = $unsigned($random(seed)) % 2;
    w = $unsigned($random(seed)) % 4;
    tag = (t == 0) ? 20'h12345 : (t == 1) ? 20'h0ABCD : 20'h54321;
    return line_addr(tag, 8'h10 + 8'(s), 2'(w));
  endfunction

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////
  // response monitor
  ////////////////////

  always @(negedge clk) begin
    if (resetn) begin
      if (data_ok) begin
        responses++;
        assert (pending) else begin
          errors++;
          $display("data_ok arrived with no request outstanding at %0t", $time);
        end
        assert (rdata == mem_word(cur_addr)) else begin
          errors++;
          $display("Error at %0t: addr %h rdata %h expected %h", $time, cur_addr, rdata,
                   mem_word(cur_addr));
        end
        if (want_hit) begin
          assert (cycle - acc_cycle == 2) else begin
            errors++;
            $display("Error at %0t: hit latency %0d cycles, expected 2", $time,
                     cycle - acc_cycle);
          end
        end
        pending = 1'b0;
      end else if (pending) begin
        assert (!addr_ok) else begin
          errors++;
          $display("addr_ok went high before data_ok at %0t", $time);
        end
      end
      if (rd_req) begin
        miss_seen = 1'b1;
        assert (pending && rd_addr == (cur_addr & 32'hFFFF_FFF0)) else begin
          errors++;
          $display("Error at %0t: rd_addr %h for request %h", $time, rd_addr, cur_addr);
        end
        assert (!want_hit) else begin
          errors++;
          $display("memory read issued for a line that should be cached, at %0t", $time);
        end
      end
      if (prev_wait) begin
        assert (rd_req && rd_addr == prev_rd_addr) else begin
          errors++;
          $display("rd_req dropped or rd_addr changed before rd_rdy at %0t", $time);
        end
      end
      prev_wait    = rd_req && !rd_rdy;
      prev_rd_addr = rd_addr;
      if (valid && addr_ok) begin                   // accepted at the next edge
        pending   = 1'b1;
        cur_addr  = addr;
        acc_cycle = cycle;
        miss_seen = 1'b0;
        requests++;
      end
    end
  end

  ////////////////////
  // memory model
  ////////////////////

  initial begin
    cache_pkg::addr_t fill_addr;
    int delay;
    int gap;
    forever begin
      @(negedge clk);
      if (resetn && rd_req) begin
        fill_addr = rd_addr;
        delay = $unsigned($random(seed)) % 4;
        @(posedge clk);
        #1;
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        rd_rdy = 1'b1;
        @(posedge clk);
        #1;
        rd_rdy = 1'b0;
        for (int i = 0; i < 4; i++) begin
          gap = $unsigned($random(seed)) % 3;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
          ret_valid = 1'b1;
          ret_last  = (i == 3);
          ret_data  = mem_word(fill_addr + 32'(4 * i));
          @(posedge clk);
          #1;
          ret_valid = 1'b0;
          ret_last  = 1'b0;
        end
      end
    end
  end

  // one request, back once data_ok is seen
  task automatic read_word(input cache_pkg::addr_t a, input logic must_hit,
                           output logic missed);
    @(posedge clk);
    #1;
    want_hit = must_hit;
    valid    = 1'b1;
    addr     = a;
    do @(negedge clk); while (!addr_ok);
    @(posedge clk);
    #1;
    valid = 1'b0;
    do @(negedge clk); while (!data_ok);
    missed = miss_seen;
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic missed;
    logic found;
    cache_pkg::addr_t a;
    cache_pkg::addr_t b;
    resetn    = 1'b0;
    valid     = 1'b0;
    addr      = '0;
    rd_rdy    = 1'b0;
    ret_valid = 1'b0;
    ret_last  = 1'b0;
    ret_data  = '0;
    repeat (3) @(posedge clk);
    #1;
    resetn = 1'b1;
    @(negedge clk);
    assert (addr_ok && !data_ok && !rd_req) else begin
      errors++;
      $display("Error at %0t: after reset addr_ok %b data_ok %b rd_req %b", $time,
               addr_ok, data_ok, rd_req);
    end

    // cold miss, then another word of the same line
    read_word(line_addr(20'h12345, 8'h40, 2'd1), 1'b0, missed);
    assert (missed) else begin
      errors++;
      $display("first read of a cold line did not go to memory");
    end
    read_word(line_addr(20'h12345, 8'h40, 2'd3), 1'b1, missed);

    // same index, two tags; a hit on a right after b means both ways are in use
    a = line_addr(20'h0ABCD, 8'h80, 2'd0);
    b = line_addr(20'h54321, 8'h80, 2'd2);
    read_word(a, 1'b0, missed);
    read_word(b, 1'b0, missed);
    found = 1'b0;
    for (int k = 0; k < 16 && !found; k++) begin
      read_word(a, 1'b0, missed);
      if (!missed) begin
        found = 1'b1;
      end else begin
        read_word(b, 1'b0, missed);
      end
    end
    assert (found) else begin
      errors++;
      $display("two lines of one set were never held together");
    end
    if (found) begin
      read_word(b, 1'b1, missed);
      read_word(a, 1'b1, missed);
      read_word(b, 1'b1, missed);
    end

    for (int k = 0; k < NUM_REQUESTS; k++) begin
      read_word(pool_addr(), 1'b0, missed);
    end

    repeat (4) @(posedge clk);
    assert (requests == responses) else begin
      errors++;
      $display("%0d requests accepted but %0d responses seen", requests, responses);
    end
    $display("summary: %0d requests, %0d responses, %0d errors", requests, responses, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* way_ram.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module way_ram #(
  parameter type entry_t = cache_pkg::word_t
) (
  input  logic              clk,
  input  logic              we,
  input  cache_pkg::index_t addr,
  input  entry_t            wdata,
  output entry_t            rdata
);

  entry_t mem [`CACHE_SETS];

  // single port, read returns the old entry on a write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule
